//--- dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Cache geometry

// Number of sets, each holding two ways
`define DC_LINES 16

// 32-bit words per cache line
`define DC_WORDS 4

// Stored tag width, sized so tag, index and offsets cover the memory
`define DC_TAG_BITS 4

// Backing memory

// Depth in 32-bit words, addresses wrap modulo this depth
`define MEM_WORDS 1024

// Idle cycles the memory waits before each ack
`define MEM_WAIT 2

`endif

//--- dcachePkg.sv
`include "dcache_cfg.svh"

package dcachePkg;

  // Derived address field widths
  localparam int IndexBits = $clog2(`DC_LINES);
  localparam int WordBits = $clog2(`DC_WORDS);
  localparam int UnusedBits = 31 - `DC_TAG_BITS - IndexBits - WordBits - 2;

  // Wishbone classic master request, used on both buses
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [3:0] sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wbReq_t;

  // Wishbone classic slave response
  typedef struct packed {
    logic ack;
    logic [31:0] dat;
  } wbRsp_t;

  // Processor address split into cache fields
  typedef struct packed {
    logic uncached;
    logic [UnusedBits-1:0] unused;
    logic [`DC_TAG_BITS-1:0] tag;
    logic [IndexBits-1:0] index;
    logic [WordBits-1:0] word;
    logic [1:0] byteOff;
  } cpuAddr_t;

  // One tag array entry
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [`DC_TAG_BITS-1:0] tag;
  } tagEntry_t;

  // Whole data line, word 0 in the low bits
  typedef logic [`DC_WORDS-1:0][31:0] cacheLine_t;

  typedef enum logic [2:0] {
    READY,
    WRITEBACK,
    MEMREAD,
    FLUSHSCAN,
    UNCACHED,
    RESPOND
  } ctrlState_t;

  // Memory contents after reset: word index in both halves
  function automatic logic [31:0] memPattern(input logic [31:0] wordIndex);
    return {wordIndex[15:0], wordIndex[15:0]};
  endfunction

endpackage

//--- wayArray.sv
`timescale 1ns/100ps

module wayArray #(
  parameter type entryType = logic [31:0],
  parameter int depth = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic [$clog2(depth)-1:0] rdIndex,
  input  logic we,
  input  logic [$clog2(depth)-1:0] wrIndex,
  input  entryType wrEntry,
  output entryType rdEntry
);

  entryType entries [depth];

  // Single write port, one entry per clock
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      // Cleared so every tag starts invalid and clean
      for (int i = 0; i < depth; i++) begin
        entries[i] <= '0;
      end
    end else if (we) begin
      entries[wrIndex] <= wrEntry;
    end
  end

  // Asynchronous read, the controller decides in the same cycle
  assign rdEntry = entries[rdIndex];

endmodule

//--- cacheController.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module cacheController (
  input  logic clk,
  input  logic reset,
  input  logic flushReq,
  input  dcachePkg::wbReq_t cpuReq,
  output dcachePkg::wbRsp_t cpuRsp,
  output logic flushBusy,
  output dcachePkg::wbReq_t memReq,
  input  dcachePkg::wbRsp_t memRsp,
  output logic [dcachePkg::IndexBits-1:0] tagIndex,
  output logic [1:0] tagWe,
  output dcachePkg::tagEntry_t tagWrEntry,
  input  dcachePkg::tagEntry_t tagRd0,
  input  dcachePkg::tagEntry_t tagRd1,
  output logic [1:0] dataWe,
  output dcachePkg::cacheLine_t dataWrEntry,
  input  dcachePkg::cacheLine_t dataRd0,
  input  dcachePkg::cacheLine_t dataRd1
);
  import dcachePkg::*;

  localparam logic [WordBits-1:0] LastWord = WordBits'(`DC_WORDS - 1);
  localparam logic [IndexBits:0] LastFlush = '1;

  ctrlState_t state, nextState;
  cpuAddr_t reqAddr, wbAddr, fillAddr;
  logic cpuActive;
  logic hit0, hit1, anyHit, hitWay;
  logic missWay, curWay, victimWay;
  logic memGap, lastWord;
  logic [WordBits-1:0] wordCnt;
  logic [IndexBits:0] flushCnt;
  logic flushWay;
  logic [IndexBits-1:0] flushIndex;
  logic [`DC_LINES-1:0] lru;
  tagEntry_t curTag;
  cacheLine_t hitLine, curLine, mergeLine, fillLine;
  logic [31:0] rspData;

  assign reqAddr = cpuAddr_t'(cpuReq.adr);
  assign cpuActive = cpuReq.cyc && cpuReq.stb;

  // Flush counter walks way 0 then way 1 of each set
  assign flushWay = flushCnt[0];
  assign flushIndex = flushCnt[IndexBits:1];
  assign tagIndex = flushBusy ? flushIndex : reqAddr.index;

  // Hit detection
  assign hit0 = tagRd0.valid && (tagRd0.tag == reqAddr.tag);
  assign hit1 = tagRd1.valid && (tagRd1.tag == reqAddr.tag);
  assign anyHit = hit0 || hit1;
  assign hitWay = hit1;
  assign hitLine = hitWay ? dataRd1 : dataRd0;

  // Victim: invalid way first (way 0 preferred), else the LRU way
  always_comb begin
    if (!tagRd0.valid) begin
      missWay = 1'b0;
    end else if (!tagRd1.valid) begin
      missWay = 1'b1;
    end else begin
      missWay = lru[reqAddr.index];
    end
  end

  // Way under inspection in the current state
  always_comb begin
    case (state)
      READY:     curWay = missWay;
      FLUSHSCAN: curWay = flushWay;
      default:   curWay = victimWay;
    endcase
  end

  assign curTag = curWay ? tagRd1 : tagRd0;
  assign curLine = curWay ? dataRd1 : dataRd0;
  assign lastWord = (wordCnt == LastWord);

  // Byte-select merge of write data into the hit word
  always_comb begin
    mergeLine = hitLine;
    for (int b = 0; b < 4; b++) begin
      if (cpuReq.sel[b]) begin
        mergeLine[reqAddr.word][8*b +: 8] = cpuReq.dat[8*b +: 8];
      end
    end
  end

  // Line transfer addresses, word by word
  always_comb begin
    wbAddr = '0;
    wbAddr.tag = curTag.tag;
    wbAddr.index = tagIndex;
    wbAddr.word = wordCnt;
    fillAddr = '0;
    fillAddr.tag = reqAddr.tag;
    fillAddr.index = reqAddr.index;
    fillAddr.word = wordCnt;
  end

  // Next state, array writes and memory bus
  always_comb begin
    nextState = state;
    tagWe = '0;
    dataWe = '0;
    tagWrEntry = '0;
    dataWrEntry = mergeLine;
    memReq = '0;
    case (state)
      READY: begin
        if (cpuActive) begin
          if (reqAddr.uncached) begin
            nextState = UNCACHED;
          end else if (anyHit) begin
            nextState = RESPOND;
            if (cpuReq.we) begin
              tagWe[hitWay] = 1'b1;
              dataWe[hitWay] = 1'b1;
              tagWrEntry = '{valid: 1'b1, dirty: 1'b1, tag: reqAddr.tag};
            end
          end else if (curTag.valid && curTag.dirty) begin
            nextState = WRITEBACK;
          end else begin
            nextState = MEMREAD;
          end
        end else if (flushReq) begin
          nextState = FLUSHSCAN;
        end
      end
      WRITEBACK: begin
        memReq.cyc = 1'b1;
        memReq.stb = !memGap;
        memReq.we = 1'b1;
        memReq.sel = 4'hf;
        memReq.adr = wbAddr;
        memReq.dat = curLine[wordCnt];
        // Line now lives in memory, drop it from the cache
        if (memRsp.ack && lastWord) begin
          tagWe[curWay] = 1'b1;
          nextState = flushBusy ? FLUSHSCAN : MEMREAD;
        end
      end
      MEMREAD: begin
        memReq.cyc = 1'b1;
        memReq.stb = !memGap;
        memReq.sel = 4'hf;
        memReq.adr = fillAddr;
        // Last word goes straight from the bus into the line
        dataWrEntry = fillLine;
        dataWrEntry[wordCnt] = memRsp.dat;
        if (memRsp.ack && lastWord) begin
          tagWe[curWay] = 1'b1;
          dataWe[curWay] = 1'b1;
          tagWrEntry = '{valid: 1'b1, dirty: 1'b0, tag: reqAddr.tag};
          nextState = READY;
        end
      end
      FLUSHSCAN: begin
        if (curTag.valid && curTag.dirty) begin
          nextState = WRITEBACK;
        end else begin
          tagWe[curWay] = 1'b1;
          if (flushCnt == LastFlush) begin
            nextState = READY;
          end
        end
      end
      UNCACHED: begin
        memReq = cpuReq;
        memReq.stb = cpuReq.stb && !memGap;
        if (memRsp.ack) begin
          nextState = RESPOND;
        end
      end
      default: begin
        nextState = READY;
      end
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
      wordCnt <= '0;
      memGap <= 1'b0;
      victimWay <= 1'b0;
      lru <= '0;
      flushCnt <= '0;
      flushBusy <= 1'b0;
    end else begin
      state <= nextState;
      // Strobe stays low for one cycle after every memory ack
      memGap <= memRsp.ack;
      if (memRsp.ack && (state == WRITEBACK || state == MEMREAD)) begin
        wordCnt <= wordCnt + 1'b1;
      end
      if (state == READY && cpuActive && !reqAddr.uncached) begin
        if (anyHit) begin
          lru[reqAddr.index] <= !hitWay;
        end else begin
          victimWay <= missWay;
        end
      end
      if (state == READY && !cpuActive && flushReq) begin
        flushBusy <= 1'b1;
        flushCnt <= '0;
      end
      if (state == FLUSHSCAN) begin
        if (curTag.valid && curTag.dirty) begin
          victimWay <= flushWay;
        end else begin
          flushCnt <= flushCnt + 1'b1;
          if (flushCnt == LastFlush) begin
            flushBusy <= 1'b0;
          end
        end
      end
    end
  end

  // Fill buffer and response data
  always_ff @(posedge clk) begin
    if (state == MEMREAD && memRsp.ack) begin
      fillLine[wordCnt] <= memRsp.dat;
    end
    if (state == READY && cpuActive && !reqAddr.uncached && anyHit) begin
      rspData <= hitLine[reqAddr.word];
    end else if (state == UNCACHED && memRsp.ack) begin
      rspData <= memRsp.dat;
    end
  end

  assign cpuRsp.ack = (state == RESPOND);
  assign cpuRsp.dat = rspData;

endmodule

//--- memoryBank.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module memoryBank (
  input  logic clk,
  input  logic reset,
  input  dcachePkg::wbReq_t bus,
  output dcachePkg::wbRsp_t rsp
);
  import dcachePkg::*;

  localparam int AddrBits = $clog2(`MEM_WORDS);
  localparam int CntBits = $clog2(`MEM_WAIT + 2);

  logic [31:0] mem [`MEM_WORDS];
  logic [AddrBits-1:0] wordIdx;
  logic [CntBits-1:0] waitCnt;
  logic waitDone;

  // Word address, wrapping at the memory depth
  assign wordIdx = bus.adr[AddrBits+1:2];
  assign waitDone = (waitCnt == CntBits'(`MEM_WAIT));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= memPattern(32'(i));
      end
      waitCnt <= '0;
      rsp <= '0;
    end else begin
      // Ack is a single-cycle pulse
      rsp.ack <= 1'b0;
      if (bus.cyc && bus.stb && !rsp.ack) begin
        if (waitDone) begin
          waitCnt <= '0;
          rsp.ack <= 1'b1;
          if (bus.we) begin
            for (int b = 0; b < 4; b++) begin
              if (bus.sel[b]) begin
                mem[wordIdx][8*b +: 8] <= bus.dat[8*b +: 8];
              end
            end
          end else begin
            rsp.dat <= mem[wordIdx];
          end
        end else begin
          waitCnt <= waitCnt + 1'b1;
        end
      end else begin
        // Restart the wait count for the next strobe
        waitCnt <= '0;
      end
    end
  end

endmodule

//--- cacheSubsystem.sv
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module cacheSubsystem (
  input  logic clk,
  input  logic reset,
  input  logic flushReq,
  input  dcachePkg::wbReq_t cpuReq,
  output dcachePkg::wbRsp_t cpuRsp,
  output logic flushBusy
);
  import dcachePkg::*;

  // Memory side bus
  wbReq_t memReq;
  wbRsp_t memRsp;

  // Way array interface
  logic [IndexBits-1:0] tagIndex;
  logic [1:0] tagWe;
  logic [1:0] dataWe;
  tagEntry_t tagWrEntry;
  tagEntry_t tagRd0;
  tagEntry_t tagRd1;
  cacheLine_t dataWrEntry;
  cacheLine_t dataRd0;
  cacheLine_t dataRd1;

  cacheController i_cacheController (
    .clk        (clk),
    .reset      (reset),
    .flushReq   (flushReq),
    .cpuReq     (cpuReq),
    .cpuRsp     (cpuRsp),
    .flushBusy  (flushBusy),
    .memReq     (memReq),
    .memRsp     (memRsp),
    .tagIndex   (tagIndex),
    .tagWe      (tagWe),
    .tagWrEntry (tagWrEntry),
    .tagRd0     (tagRd0),
    .tagRd1     (tagRd1),
    .dataWe     (dataWe),
    .dataWrEntry(dataWrEntry),
    .dataRd0    (dataRd0),
    .dataRd1    (dataRd1)
  );

  // Tag ways
  wayArray #(.entryType(tagEntry_t), .depth(`DC_LINES)) tagWay0 (
    .clk(clk), .reset(reset), .rdIndex(tagIndex), .we(tagWe[0]),
    .wrIndex(tagIndex), .wrEntry(tagWrEntry), .rdEntry(tagRd0)
  );

  wayArray #(.entryType(tagEntry_t), .depth(`DC_LINES)) tagWay1 (
    .clk(clk), .reset(reset), .rdIndex(tagIndex), .we(tagWe[1]),
    .wrIndex(tagIndex), .wrEntry(tagWrEntry), .rdEntry(tagRd1)
  );

  // Data ways
  wayArray #(.entryType(cacheLine_t), .depth(`DC_LINES)) dataWay0 (
    .clk(clk), .reset(reset), .rdIndex(tagIndex), .we(dataWe[0]),
    .wrIndex(tagIndex), .wrEntry(dataWrEntry), .rdEntry(dataRd0)
  );

  wayArray #(.entryType(cacheLine_t), .depth(`DC_LINES)) dataWay1 (
    .clk(clk), .reset(reset), .rdIndex(tagIndex), .we(dataWe[1]),
    .wrIndex(tagIndex), .wrEntry(dataWrEntry), .rdEntry(dataRd1)
  );

  memoryBank i_memoryBank (
    .clk  (clk),
    .reset(reset),
    .bus  (memReq),
    .rsp  (memRsp)
  );

endmodule

//--- tbCacheSubsystem.sv
`timescale 1ns/100ps

module tbCacheSubsystem;
  import dcachePkg::*;

  // One operation from the test file
  typedef struct packed {
    logic [7:0] op;
    logic [31:0] addr;
    logic [3:0] sel;
    logic [31:0] wdata;
    logic [31:0] expData;
    logic expHit;
  } testVec_t;

  logic clk;
  logic reset;
  logic flushReq;
  wbReq_t cpuReq;
  wbRsp_t cpuRsp;
  logic flushBusy;

  testVec_t tests[$];
  logic testsLoaded = 1'b0;
  int errorCount = 0;
  logic [31:0] lcgState;

  cacheSubsystem i_cacheSubsystem (
    .clk      (clk),
    .reset    (reset),
    .flushReq (flushReq),
    .cpuReq   (cpuReq),
    .cpuRsp   (cpuRsp),
    .flushBusy(flushBusy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopOnError();
    errorCount++;
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Linear congruential generator for the idle gaps
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 16;
  endfunction

  task automatic checkData(input wbRsp_t rsp, input logic [31:0] expected,
                           input logic [31:0] addr);
    if (rsp.dat !== expected) begin
      $display("CHECK FAILED cpuRsp.dat at adr %h: got %h expected %h",
               addr, rsp.dat, expected);
      stopOnError();
    end
  endtask

  // Hit means ack exactly one cycle after stb is seen
  task automatic checkLatency(input int latency, input logic expHit,
                              input logic [31:0] addr);
    logic gotHit;
    gotHit = (latency == 1);
    if (gotHit !== expHit) begin
      $display("CHECK FAILED cpuRsp.ack hit at adr %h: got %h expected %h (latency %0d)",
               addr, gotHit, expHit, latency);
      stopOnError();
    end
  endtask

  // Busy flag rises one cycle after the request
  task automatic checkBusy(input logic busy, input logic expected);
    if (busy !== expected) begin
      $display("CHECK FAILED flushBusy: got %h expected %h", busy, expected);
      stopOnError();
    end
  endtask

  task automatic loadTests();
    int fd;
    int code;
    int hitIn;
    logic [8*8-1:0] opText;
    logic [8*200-1:0] lineText;
    logic [31:0] addrIn;
    logic [31:0] selIn;
    logic [31:0] wdataIn;
    logic [31:0] expIn;
    testVec_t vec;
    fd = $fopen("cacheTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file cacheTests.txt");
      stopOnError();
    end
    opText = '0;
    code = $fscanf(fd, "%s", opText);
    while (code == 1) begin
      if (opText == "#") begin
        code = $fgets(lineText, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %d", addrIn, selIn, wdataIn, expIn, hitIn);
        if (code != 5 || !(opText == "R" || opText == "W" || opText == "F")) begin
          $display("The test file has a malformed line after %0d operations", tests.size());
          stopOnError();
        end
        vec.op = opText[7:0];
        vec.addr = addrIn;
        vec.sel = selIn[3:0];
        vec.wdata = wdataIn;
        vec.expData = expIn;
        vec.expHit = hitIn[0];
        tests.push_back(vec);
      end
      opText = '0;
      code = $fscanf(fd, "%s", opText);
    end
    $fclose(fd);
    testsLoaded = 1'b1;
  endtask

  // Single classic cycle held until ack
  task automatic issueAccess(input testVec_t t);
    wbReq_t req;
    wbRsp_t rsp;
    int latency;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = (t.op == "W");
    req.sel = t.sel;
    req.adr = t.addr;
    req.dat = t.wdata;
    @(posedge clk);
    cpuReq <= req;
    // DUT sees stb at this edge
    @(posedge clk);
    latency = 0;
    rsp = '0;
    while (!rsp.ack) begin
      @(posedge clk);
      latency++;
      rsp = cpuRsp;
    end
    cpuReq <= '0;
    checkLatency(latency, t.expHit, t.addr);
    if (t.op == "R") begin
      checkData(rsp, t.expData, t.addr);
    end
  endtask

  task automatic flushCache();
    @(posedge clk);
    flushReq <= 1'b1;
    @(posedge clk);
    flushReq <= 1'b0;
    @(posedge clk);
    checkBusy(flushBusy, 1'b1);
    while (flushBusy) begin
      @(posedge clk);
    end
  endtask

  // Watchdog scaled to the number of operations
  initial begin
    wait (testsLoaded);
    repeat (tests.size() * 200 + 1000) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles",
             tests.size() * 200 + 1000);
    stopOnError();
  end

  initial begin
    reset = 1'b1;
    flushReq = 1'b0;
    cpuReq = '0;
    lcgState = 32'd80701;
    loadTests();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < tests.size(); i++) begin
      repeat (nextRandom() % 4) @(posedge clk);
      if (tests[i].op == "F") begin
        flushCache();
      end else begin
        issueAccess(tests[i]);
      end
    end
    @(posedge clk);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
dcachePkg.sv
wayArray.sv
cacheController.sv
memoryBank.sv
cacheSubsystem.sv
tbCacheSubsystem.sv

//--- cacheTests.txt
# op addr sel wdata expData expHit
# addr, sel and data in hex, expHit is 1 for a hit, data of writes is not checked
R 00000010 f 00000000 00040004 0
R 00000014 f 00000000 00050005 1
R 0000001C f 00000000 00070007 1
R 00000020 f 00000000 00080008 0
W 00000014 3 AABBCCDD 00000000 1
R 00000014 f 00000000 0005CCDD 1
W 00000018 8 11223344 00000000 1
R 00000018 f 00000000 11060006 1
W 00000028 6 12345678 00000000 1
R 00000028 f 00000000 0034560A 1
# third tag in set 1 evicts the dirty line
R 00000110 f 00000000 00440044 0
R 00000114 f 00000000 00450045 1
R 00000210 f 00000000 00840084 0
R 00000218 f 00000000 00860086 1
R 00000014 f 00000000 0005CCDD 0
R 00000018 f 00000000 11060006 1
R 00000110 f 00000000 00440044 0
R 00000214 f 00000000 00850085 0
# uncached accesses with address bit 31
R 80000030 f 00000000 000C000C 0
W 80000034 f CAFEF00D 00000000 0
R 80000034 f 00000000 CAFEF00D 0
R 80000034 f 00000000 CAFEF00D 0
R 00000034 f 00000000 CAFEF00D 0
W 80000038 1 000000AB 00000000 0
R 80000038 f 00000000 000E00AB 0
# dirty writes, then flush
W 00000030 f 5A5A5A5A 00000000 1
W 00000310 c 77665544 00000000 0
R 00000310 f 00000000 776600C4 1
F 00000000 0 00000000 00000000 0
R 00000030 f 00000000 5A5A5A5A 0
R 00000310 f 00000000 776600C4 0
R 00000028 f 00000000 0034560A 0
R 00000018 f 00000000 11060006 0
R 00000034 f 00000000 CAFEF00D 1
R 80000030 f 00000000 5A5A5A5A 0
F 00000000 0 00000000 00000000 0
R 00000030 f 00000000 5A5A5A5A 0
